//--- verilog/fight_state_pkg.sv
package fight_state_pkg;

	// fighter states, shared by the state machine and the hit resolver.
	typedef enum logic [3:0] {
		S_IDLE           = 4'd0,
		S_MOVEFORWARD    = 4'd1,
		S_MOVEBACKWARDS  = 4'd2,
		S_B_ATTACK_START = 4'd3,
		S_B_ATTACK_END   = 4'd4,
		S_B_ATTACK_PULL  = 4'd5
	} fighter_state_t;

	// bit 1 set when p1 lands, bit 0 set when p2 lands.
	typedef enum logic [1:0] {
		NO_HIT     = 2'b00,
		P2_HITS_P1 = 2'b01,
		P1_HITS_P2 = 2'b10,
		BOTH_HIT   = 2'b11
	} hit_result_t;

	localparam int HEALTH_W = 8;

endpackage

//--- verilog/arena_geom_pkg.sv
package arena_geom_pkg;

	localparam int COORD_W = 10;

	// limits of a fighter's left edge.
	localparam logic [COORD_W-1:0] ARENA_MIN_X = 10'd16;
	localparam logic [COORD_W-1:0] ARENA_MAX_X = 10'd560;

	// bottom of every body.
	localparam logic [COORD_W-1:0] GROUND_Y = 10'd400;

	localparam logic [COORD_W-1:0] BODY_W = 10'd48;
	localparam logic [COORD_W-1:0] BODY_H = 10'd96;

	// arm reach and its vertical band.
	localparam logic [COORD_W-1:0] ARM_LEN = 10'd40;
	localparam logic [COORD_W-1:0] ARM_Y1  = 10'd330;
	localparam logic [COORD_W-1:0] ARM_Y2  = 10'd350;

	localparam logic [COORD_W-1:0] P1_START_X = 10'd100;
	localparam logic [COORD_W-1:0] P2_START_X = 10'd480;

endpackage

//--- verilog/fighter_fsm.sv
module fighter_fsm #(
	parameter bit FACE_RIGHT = 1'b1,
	parameter int MOVE_STEP = 4,
	parameter int ATTACK_START_FRAMES = 3,
	parameter int ATTACK_ACTIVE_FRAMES = 4,
	parameter int ATTACK_PULL_FRAMES = 3,
	parameter logic [arena_geom_pkg::COORD_W-1:0] START_X = arena_geom_pkg::P1_START_X
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  frame_tick,
	input  logic                                  game_over,
	input  logic                                  forward,
	input  logic                                  backward,
	input  logic                                  attack,
	output fight_state_pkg::fighter_state_t       state,
	output logic [arena_geom_pkg::COORD_W-1:0]    pos_x
);

	localparam int CW = arena_geom_pkg::COORD_W;
	localparam int CNT_W = $clog2(ATTACK_START_FRAMES + ATTACK_ACTIVE_FRAMES +
		ATTACK_PULL_FRAMES + 1);

	localparam logic [CNT_W-1:0] START_LAST = CNT_W'(ATTACK_START_FRAMES - 1);
	localparam logic [CNT_W-1:0] ACTIVE_LAST = CNT_W'(ATTACK_ACTIVE_FRAMES - 1);
	localparam logic [CNT_W-1:0] PULL_LAST = CNT_W'(ATTACK_PULL_FRAMES - 1);
	localparam logic [CW-1:0] STEP = CW'(MOVE_STEP);

	fight_state_pkg::fighter_state_t state_next;
	logic [CNT_W-1:0] frame_cnt;
	logic [CNT_W-1:0] cnt_next;
	logic [CW-1:0] pos_next;
	logic step_right;
	logic step_left;

	// ticks spent in the current attack phase.
	always_comb begin
		state_next = state;
		cnt_next = frame_cnt + 1'b1;
		case (state)
			fight_state_pkg::S_B_ATTACK_START: begin
				if (frame_cnt == START_LAST) begin
					state_next = fight_state_pkg::S_B_ATTACK_END;
					cnt_next = '0;
				end
			end
			fight_state_pkg::S_B_ATTACK_END: begin
				if (frame_cnt == ACTIVE_LAST) begin
					state_next = fight_state_pkg::S_B_ATTACK_PULL;
					cnt_next = '0;
				end
			end
			fight_state_pkg::S_B_ATTACK_PULL: begin
				if (frame_cnt == PULL_LAST) begin
					state_next = fight_state_pkg::S_IDLE;
					cnt_next = '0;
				end
			end
			default: begin
				cnt_next = '0;
				if (attack)
					state_next = fight_state_pkg::S_B_ATTACK_START;
				else if (forward)
					state_next = fight_state_pkg::S_MOVEFORWARD;
				else if (backward)
					state_next = fight_state_pkg::S_MOVEBACKWARDS;
				else
					state_next = fight_state_pkg::S_IDLE;
			end
		endcase
	end

	// forward is toward larger x only for a fighter facing right.
	assign step_right = FACE_RIGHT ? (state_next == fight_state_pkg::S_MOVEFORWARD) :
		(state_next == fight_state_pkg::S_MOVEBACKWARDS);
	assign step_left = FACE_RIGHT ? (state_next == fight_state_pkg::S_MOVEBACKWARDS) :
		(state_next == fight_state_pkg::S_MOVEFORWARD);

	always_comb begin
		pos_next = pos_x;
		if (step_right) begin
			if (pos_x >= arena_geom_pkg::ARENA_MAX_X - STEP)
				pos_next = arena_geom_pkg::ARENA_MAX_X;
			else
				pos_next = pos_x + STEP;
		end else if (step_left) begin
			if (pos_x <= arena_geom_pkg::ARENA_MIN_X + STEP)
				pos_next = arena_geom_pkg::ARENA_MIN_X;
			else
				pos_next = pos_x - STEP;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= fight_state_pkg::S_IDLE;
			frame_cnt <= '0;
			pos_x <= START_X;
		end else if (frame_tick && !game_over) begin
			state <= state_next;
			frame_cnt <= cnt_next;
			pos_x <= pos_next;
		end
	end

endmodule

//--- verilog/fighter_boxes.sv
module fighter_boxes #(
	parameter bit FACE_RIGHT = 1'b1
) (
	input  logic [arena_geom_pkg::COORD_W-1:0] pos_x,
	output logic [arena_geom_pkg::COORD_W-1:0] hurt_x1,
	output logic [arena_geom_pkg::COORD_W-1:0] hurt_x2,
	output logic [arena_geom_pkg::COORD_W-1:0] hurt_y1,
	output logic [arena_geom_pkg::COORD_W-1:0] hurt_y2,
	output logic [arena_geom_pkg::COORD_W-1:0] arm_x1,
	output logic [arena_geom_pkg::COORD_W-1:0] arm_x2,
	output logic [arena_geom_pkg::COORD_W-1:0] arm_y1,
	output logic [arena_geom_pkg::COORD_W-1:0] arm_y2
);

	// main hurtbox stands on the ground line.
	assign hurt_x1 = pos_x;
	assign hurt_x2 = pos_x + arena_geom_pkg::BODY_W;
	assign hurt_y1 = arena_geom_pkg::GROUND_Y - arena_geom_pkg::BODY_H;
	assign hurt_y2 = arena_geom_pkg::GROUND_Y;

	assign arm_y1 = arena_geom_pkg::ARM_Y1;
	assign arm_y2 = arena_geom_pkg::ARM_Y2;

	if (FACE_RIGHT) begin : g_arm_right
		assign arm_x1 = pos_x + arena_geom_pkg::BODY_W;
		assign arm_x2 = pos_x + arena_geom_pkg::BODY_W + arena_geom_pkg::ARM_LEN;
	end else begin : g_arm_left
		// clamped at the left screen edge.
		assign arm_x1 = (pos_x > arena_geom_pkg::ARM_LEN) ?
			pos_x - arena_geom_pkg::ARM_LEN : '0;
		assign arm_x2 = pos_x;
	end

endmodule

//--- verilog/collision_detect.sv
module collision_detect (
	input  logic [arena_geom_pkg::COORD_W-1:0] a_x1,
	input  logic [arena_geom_pkg::COORD_W-1:0] a_x2,
	input  logic [arena_geom_pkg::COORD_W-1:0] a_y1,
	input  logic [arena_geom_pkg::COORD_W-1:0] a_y2,
	input  logic [arena_geom_pkg::COORD_W-1:0] b_x1,
	input  logic [arena_geom_pkg::COORD_W-1:0] b_x2,
	input  logic [arena_geom_pkg::COORD_W-1:0] b_y1,
	input  logic [arena_geom_pkg::COORD_W-1:0] b_y2,
	output logic                               collision_result
);

	// edges touching count as overlap.
	assign collision_result = (a_x1 <= b_x2) && (b_x1 <= a_x2) &&
		(a_y1 <= b_y2) && (b_y1 <= a_y2);

endmodule

//--- verilog/hit_detect.sv
module hit_detect (
	input  fight_state_pkg::fighter_state_t    p1_state,
	input  logic [arena_geom_pkg::COORD_W-1:0] p1_arm_x1,
	input  logic [arena_geom_pkg::COORD_W-1:0] p1_arm_x2,
	input  logic [arena_geom_pkg::COORD_W-1:0] p1_arm_y1,
	input  logic [arena_geom_pkg::COORD_W-1:0] p1_arm_y2,
	input  logic [arena_geom_pkg::COORD_W-1:0] p1_hurt_x1,
	input  logic [arena_geom_pkg::COORD_W-1:0] p1_hurt_x2,
	input  logic [arena_geom_pkg::COORD_W-1:0] p1_hurt_y1,
	input  logic [arena_geom_pkg::COORD_W-1:0] p1_hurt_y2,
	input  fight_state_pkg::fighter_state_t    p2_state,
	input  logic [arena_geom_pkg::COORD_W-1:0] p2_arm_x1,
	input  logic [arena_geom_pkg::COORD_W-1:0] p2_arm_x2,
	input  logic [arena_geom_pkg::COORD_W-1:0] p2_arm_y1,
	input  logic [arena_geom_pkg::COORD_W-1:0] p2_arm_y2,
	input  logic [arena_geom_pkg::COORD_W-1:0] p2_hurt_x1,
	input  logic [arena_geom_pkg::COORD_W-1:0] p2_hurt_x2,
	input  logic [arena_geom_pkg::COORD_W-1:0] p2_hurt_y1,
	input  logic [arena_geom_pkg::COORD_W-1:0] p2_hurt_y2,
	output fight_state_pkg::hit_result_t       hit_result
);

	logic p1_arm_p2_body;
	logic p2_arm_p1_body;
	logic arm_clash;

	collision_detect u_p1_arm_p2_body (
		.a_x1(p1_arm_x1), .a_x2(p1_arm_x2), .a_y1(p1_arm_y1), .a_y2(p1_arm_y2),
		.b_x1(p2_hurt_x1), .b_x2(p2_hurt_x2), .b_y1(p2_hurt_y1), .b_y2(p2_hurt_y2),
		.collision_result(p1_arm_p2_body)
	);

	collision_detect u_p2_arm_p1_body (
		.a_x1(p2_arm_x1), .a_x2(p2_arm_x2), .a_y1(p2_arm_y1), .a_y2(p2_arm_y2),
		.b_x1(p1_hurt_x1), .b_x2(p1_hurt_x2), .b_y1(p1_hurt_y1), .b_y2(p1_hurt_y2),
		.collision_result(p2_arm_p1_body)
	);

	collision_detect u_arm_clash (
		.a_x1(p1_arm_x1), .a_x2(p1_arm_x2), .a_y1(p1_arm_y1), .a_y2(p1_arm_y2),
		.b_x1(p2_arm_x1), .b_x2(p2_arm_x2), .b_y1(p2_arm_y1), .b_y2(p2_arm_y2),
		.collision_result(arm_clash)
	);

	// only an arm in its active phase can land.
	always_comb begin
		hit_result = fight_state_pkg::NO_HIT;
		case (p1_state)
			fight_state_pkg::S_B_ATTACK_END: begin
				case (p2_state)
					fight_state_pkg::S_B_ATTACK_END:
						if (arm_clash) hit_result = fight_state_pkg::BOTH_HIT;
					fight_state_pkg::S_B_ATTACK_PULL:
						if (arm_clash) hit_result = fight_state_pkg::P1_HITS_P2;
					default:
						if (p1_arm_p2_body) hit_result = fight_state_pkg::P1_HITS_P2;
				endcase
			end
			fight_state_pkg::S_B_ATTACK_PULL: begin
				// a retracting arm is still hittable.
				if (p2_state == fight_state_pkg::S_B_ATTACK_END && arm_clash)
					hit_result = fight_state_pkg::P2_HITS_P1;
			end
			default: begin
				if (p2_state == fight_state_pkg::S_B_ATTACK_END && p2_arm_p1_body)
					hit_result = fight_state_pkg::P2_HITS_P1;
			end
		endcase
	end

endmodule

//--- verilog/health_tracker.sv
module health_tracker #(
	parameter int MAX_HEALTH = 100,
	parameter int HIT_DAMAGE = 10
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 frame_tick,
	input  fight_state_pkg::hit_result_t         hit_result,
	output logic [fight_state_pkg::HEALTH_W-1:0] p1_health,
	output logic [fight_state_pkg::HEALTH_W-1:0] p2_health,
	output logic                                 game_over
);

	localparam int HW = fight_state_pkg::HEALTH_W;
	localparam logic [HW-1:0] FULL = HW'(MAX_HEALTH);
	localparam logic [HW-1:0] DAMAGE = HW'(HIT_DAMAGE);

	fight_state_pkg::hit_result_t prev_hit;
	logic [1:0] hit_rise;
	logic [HW-1:0] p1_after_hit;
	logic [HW-1:0] p2_after_hit;

	// a held hit counts once.
	assign hit_rise = hit_result & ~prev_hit;

	assign p1_after_hit = (p1_health > DAMAGE) ? p1_health - DAMAGE : '0;
	assign p2_after_hit = (p2_health > DAMAGE) ? p2_health - DAMAGE : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			prev_hit <= fight_state_pkg::NO_HIT;
			p1_health <= FULL;
			p2_health <= FULL;
			game_over <= 1'b0;
		end else if (frame_tick && !game_over) begin
			prev_hit <= hit_result;
			// bit 0 is p2 landing on p1.
			if (hit_rise[0])
				p1_health <= p1_after_hit;
			if (hit_rise[1])
				p2_health <= p2_after_hit;
			if (p1_health == '0 || p2_health == '0)
				game_over <= 1'b1;
		end
	end

endmodule

//--- verilog/fight_core.sv
module fight_core #(
	parameter int MOVE_STEP = 4,
	parameter int ATTACK_START_FRAMES = 3,
	parameter int ATTACK_ACTIVE_FRAMES = 4,
	parameter int ATTACK_PULL_FRAMES = 3,
	parameter int MAX_HEALTH = 100,
	parameter int HIT_DAMAGE = 10
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 frame_tick,
	input  logic                                 p1_forward,
	input  logic                                 p1_backward,
	input  logic                                 p1_attack,
	input  logic                                 p2_forward,
	input  logic                                 p2_backward,
	input  logic                                 p2_attack,
	output fight_state_pkg::fighter_state_t      p1_state,
	output fight_state_pkg::fighter_state_t      p2_state,
	output logic [arena_geom_pkg::COORD_W-1:0]   p1_x,
	output logic [arena_geom_pkg::COORD_W-1:0]   p2_x,
	output fight_state_pkg::hit_result_t         hit_result,
	output logic [fight_state_pkg::HEALTH_W-1:0] p1_health,
	output logic [fight_state_pkg::HEALTH_W-1:0] p2_health,
	output logic                                 game_over
);

	localparam int CW = arena_geom_pkg::COORD_W;

	logic [CW-1:0] p1_hurt_x1, p1_hurt_x2, p1_hurt_y1, p1_hurt_y2;
	logic [CW-1:0] p1_arm_x1, p1_arm_x2, p1_arm_y1, p1_arm_y2;
	logic [CW-1:0] p2_hurt_x1, p2_hurt_x2, p2_hurt_y1, p2_hurt_y2;
	logic [CW-1:0] p2_arm_x1, p2_arm_x2, p2_arm_y1, p2_arm_y2;

	// p1 starts on the left facing right.
	fighter_fsm #(
		.FACE_RIGHT(1'b1), .MOVE_STEP(MOVE_STEP),
		.ATTACK_START_FRAMES(ATTACK_START_FRAMES),
		.ATTACK_ACTIVE_FRAMES(ATTACK_ACTIVE_FRAMES),
		.ATTACK_PULL_FRAMES(ATTACK_PULL_FRAMES),
		.START_X(arena_geom_pkg::P1_START_X)
	) u_p1_fsm (
		.clk(clk), .rst_n(rst_n), .frame_tick(frame_tick), .game_over(game_over),
		.forward(p1_forward), .backward(p1_backward), .attack(p1_attack),
		.state(p1_state), .pos_x(p1_x)
	);

	fighter_fsm #(
		.FACE_RIGHT(1'b0), .MOVE_STEP(MOVE_STEP),
		.ATTACK_START_FRAMES(ATTACK_START_FRAMES),
		.ATTACK_ACTIVE_FRAMES(ATTACK_ACTIVE_FRAMES),
		.ATTACK_PULL_FRAMES(ATTACK_PULL_FRAMES),
		.START_X(arena_geom_pkg::P2_START_X)
	) u_p2_fsm (
		.clk(clk), .rst_n(rst_n), .frame_tick(frame_tick), .game_over(game_over),
		.forward(p2_forward), .backward(p2_backward), .attack(p2_attack),
		.state(p2_state), .pos_x(p2_x)
	);

	fighter_boxes #(.FACE_RIGHT(1'b1)) u_p1_boxes (
		.pos_x(p1_x),
		.hurt_x1(p1_hurt_x1), .hurt_x2(p1_hurt_x2), .hurt_y1(p1_hurt_y1), .hurt_y2(p1_hurt_y2),
		.arm_x1(p1_arm_x1), .arm_x2(p1_arm_x2), .arm_y1(p1_arm_y1), .arm_y2(p1_arm_y2)
	);

	fighter_boxes #(.FACE_RIGHT(1'b0)) u_p2_boxes (
		.pos_x(p2_x),
		.hurt_x1(p2_hurt_x1), .hurt_x2(p2_hurt_x2), .hurt_y1(p2_hurt_y1), .hurt_y2(p2_hurt_y2),
		.arm_x1(p2_arm_x1), .arm_x2(p2_arm_x2), .arm_y1(p2_arm_y1), .arm_y2(p2_arm_y2)
	);

	hit_detect u_hit_detect (
		.p1_state(p1_state),
		.p1_arm_x1(p1_arm_x1), .p1_arm_x2(p1_arm_x2),
		.p1_arm_y1(p1_arm_y1), .p1_arm_y2(p1_arm_y2),
		.p1_hurt_x1(p1_hurt_x1), .p1_hurt_x2(p1_hurt_x2),
		.p1_hurt_y1(p1_hurt_y1), .p1_hurt_y2(p1_hurt_y2),
		.p2_state(p2_state),
		.p2_arm_x1(p2_arm_x1), .p2_arm_x2(p2_arm_x2),
		.p2_arm_y1(p2_arm_y1), .p2_arm_y2(p2_arm_y2),
		.p2_hurt_x1(p2_hurt_x1), .p2_hurt_x2(p2_hurt_x2),
		.p2_hurt_y1(p2_hurt_y1), .p2_hurt_y2(p2_hurt_y2),
		.hit_result(hit_result)
	);

	health_tracker #(
		.MAX_HEALTH(MAX_HEALTH), .HIT_DAMAGE(HIT_DAMAGE)
	) u_health (
		.clk(clk), .rst_n(rst_n), .frame_tick(frame_tick), .hit_result(hit_result),
		.p1_health(p1_health), .p2_health(p2_health), .game_over(game_over)
	);

endmodule

//--- dv/fight_core_asserts.sv
module fight_core_asserts (
	input logic                                 clk,
	input logic                                 rst_n,
	input logic                                 frame_tick,
	input fight_state_pkg::fighter_state_t      p1_state,
	input fight_state_pkg::fighter_state_t      p2_state,
	input logic [arena_geom_pkg::COORD_W-1:0]   p1_x,
	input logic [arena_geom_pkg::COORD_W-1:0]   p2_x,
	input fight_state_pkg::hit_result_t         hit_result,
	input logic [fight_state_pkg::HEALTH_W-1:0] p1_health,
	input logic [fight_state_pkg::HEALTH_W-1:0] p2_health,
	input logic                                 game_over
);
	timeunit 1ns;
	timeprecision 1ps;

	int assert_fails = 0;

	// registers only move on a frame tick.
	hold_between_ticks: assert property (@(posedge clk)
		rst_n && !frame_tick |=> $stable({p1_state, p2_state, p1_x, p2_x, hit_result,
			p1_health, p2_health, game_over}))
		else begin
			assert_fails++;
			$error("outputs changed without a frame tick");
		end

	health_no_gain: assert property (@(posedge clk)
		$past(rst_n) |-> p1_health <= $past(p1_health) && p2_health <= $past(p2_health))
		else begin
			assert_fails++;
			$error("a health value increased outside reset");
		end

	game_over_held: assert property (@(posedge clk)
		$past(rst_n) && $past(game_over) |-> game_over)
		else begin
			assert_fails++;
			$error("game_over dropped without reset");
		end

	// six encodings, the last one is the pull phase.
	state_legal: assert property (@(posedge clk)
		rst_n |-> p1_state <= fight_state_pkg::S_B_ATTACK_PULL &&
			p2_state <= fight_state_pkg::S_B_ATTACK_PULL)
		else begin
			assert_fails++;
			$error("a fighter state left the legal encodings");
		end

endmodule

bind fight_core fight_core_asserts u_asserts (
	.clk(clk), .rst_n(rst_n), .frame_tick(frame_tick),
	.p1_state(p1_state), .p2_state(p2_state), .p1_x(p1_x), .p2_x(p2_x),
	.hit_result(hit_result), .p1_health(p1_health), .p2_health(p2_health),
	.game_over(game_over)
);

//--- dv/fight_core_tb.sv
module fight_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_CYCLES = 3000;
	localparam int RESET_AGAIN_AT = 1500;
	localparam int WATCHDOG_CYCLES = NUM_CYCLES + 100;
	localparam int MOVE_STEP = 4;
	localparam int START_FRAMES = 3;
	localparam int ACTIVE_FRAMES = 4;
	localparam int PULL_FRAMES = 3;
	// not a multiple of the damage, so the last hit saturates at zero.
	localparam int MAX_HEALTH = 95;
	localparam int HIT_DAMAGE = 10;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic frame_tick = 1'b0;
	logic p1_forward = 1'b0;
	logic p1_backward = 1'b0;
	logic p1_attack = 1'b0;
	logic p2_forward = 1'b0;
	logic p2_backward = 1'b0;
	logic p2_attack = 1'b0;

	fight_state_pkg::fighter_state_t p1_state;
	fight_state_pkg::fighter_state_t p2_state;
	logic [arena_geom_pkg::COORD_W-1:0] p1_x;
	logic [arena_geom_pkg::COORD_W-1:0] p2_x;
	fight_state_pkg::hit_result_t hit_result;
	logic [fight_state_pkg::HEALTH_W-1:0] p1_health;
	logic [fight_state_pkg::HEALTH_W-1:0] p2_health;
	logic game_over;

	// reference model, index 0 is p1.
	fight_state_pkg::fighter_state_t m_state [2];
	int m_cnt [2];
	int m_x [2];
	int m_health [2];
	logic [1:0] m_prev_hit;
	logic m_game_over;

	integer seed = 66;
	int hits_landed = 0;
	int game_overs = 0;

	fight_core #(
		.MOVE_STEP(MOVE_STEP), .ATTACK_START_FRAMES(START_FRAMES),
		.ATTACK_ACTIVE_FRAMES(ACTIVE_FRAMES), .ATTACK_PULL_FRAMES(PULL_FRAMES),
		.MAX_HEALTH(MAX_HEALTH), .HIT_DAMAGE(HIT_DAMAGE)
	) u_dut (
		.clk(clk), .rst_n(rst_n), .frame_tick(frame_tick),
		.p1_forward(p1_forward), .p1_backward(p1_backward), .p1_attack(p1_attack),
		.p2_forward(p2_forward), .p2_backward(p2_backward), .p2_attack(p2_attack),
		.p1_state(p1_state), .p2_state(p2_state), .p1_x(p1_x), .p2_x(p2_x),
		.hit_result(hit_result), .p1_health(p1_health), .p2_health(p2_health),
		.game_over(game_over)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic bit overlap(input int ax1, input int ax2, input int ay1, input int ay2,
		input int bx1, input int bx2, input int by1, input int by2);
		return ax1 <= bx2 && bx1 <= ax2 && ay1 <= by2 && by1 <= ay2;
	endfunction

	// bit 1 is p1 landing, bit 0 is p2 landing.
	function automatic logic [1:0] expected_hit();
		int body_y1;
		int p2_arm_x1;
		bit p1_arm_on_body;
		bit p2_arm_on_body;
		bit clash;
		logic [1:0] hit;
		body_y1 = arena_geom_pkg::GROUND_Y - arena_geom_pkg::BODY_H;
		p2_arm_x1 = m_x[1] - arena_geom_pkg::ARM_LEN;
		if (p2_arm_x1 < 0)
			p2_arm_x1 = 0;
		p1_arm_on_body = overlap(m_x[0] + arena_geom_pkg::BODY_W,
			m_x[0] + arena_geom_pkg::BODY_W + arena_geom_pkg::ARM_LEN,
			arena_geom_pkg::ARM_Y1, arena_geom_pkg::ARM_Y2,
			m_x[1], m_x[1] + arena_geom_pkg::BODY_W, body_y1, arena_geom_pkg::GROUND_Y);
		p2_arm_on_body = overlap(p2_arm_x1, m_x[1], arena_geom_pkg::ARM_Y1,
			arena_geom_pkg::ARM_Y2, m_x[0], m_x[0] + arena_geom_pkg::BODY_W, body_y1,
			arena_geom_pkg::GROUND_Y);
		clash = overlap(m_x[0] + arena_geom_pkg::BODY_W,
			m_x[0] + arena_geom_pkg::BODY_W + arena_geom_pkg::ARM_LEN,
			arena_geom_pkg::ARM_Y1, arena_geom_pkg::ARM_Y2,
			p2_arm_x1, m_x[1], arena_geom_pkg::ARM_Y1, arena_geom_pkg::ARM_Y2);
		hit = 2'b00;
		if (m_state[0] == fight_state_pkg::S_B_ATTACK_END) begin
			if (m_state[1] == fight_state_pkg::S_B_ATTACK_END)
				hit = clash ? 2'b11 : 2'b00;
			else if (m_state[1] == fight_state_pkg::S_B_ATTACK_PULL)
				hit = clash ? 2'b10 : 2'b00;
			else
				hit = p1_arm_on_body ? 2'b10 : 2'b00;
		end else if (m_state[0] == fight_state_pkg::S_B_ATTACK_PULL) begin
			if (m_state[1] == fight_state_pkg::S_B_ATTACK_END && clash)
				hit = 2'b01;
		end else if (m_state[1] == fight_state_pkg::S_B_ATTACK_END && p2_arm_on_body) begin
			hit = 2'b01;
		end
		return hit;
	endfunction

	function automatic int phase_frames(input fight_state_pkg::fighter_state_t s);
		if (s == fight_state_pkg::S_B_ATTACK_START)
			return START_FRAMES;
		if (s == fight_state_pkg::S_B_ATTACK_END)
			return ACTIVE_FRAMES;
		return PULL_FRAMES;
	endfunction

	function automatic int damaged(input int health);
		return (health > HIT_DAMAGE) ? health - HIT_DAMAGE : 0;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < 2; i++) begin
			m_state[i] = fight_state_pkg::S_IDLE;
			m_cnt[i] = 0;
			m_health[i] = MAX_HEALTH;
		end
		m_x[0] = arena_geom_pkg::P1_START_X;
		m_x[1] = arena_geom_pkg::P2_START_X;
		m_prev_hit = 2'b00;
		m_game_over = 1'b0;
	endtask

	task automatic advance_fighter(input int idx, input bit fwd, input bit bwd, input bit atk);
		int move;
		move = 0;
		if (m_state[idx] inside {fight_state_pkg::S_B_ATTACK_START,
			fight_state_pkg::S_B_ATTACK_END, fight_state_pkg::S_B_ATTACK_PULL}) begin
			m_cnt[idx] = m_cnt[idx] + 1;
			if (m_cnt[idx] == phase_frames(m_state[idx])) begin
				m_cnt[idx] = 0;
				case (m_state[idx])
					fight_state_pkg::S_B_ATTACK_START: m_state[idx] = fight_state_pkg::S_B_ATTACK_END;
					fight_state_pkg::S_B_ATTACK_END: m_state[idx] = fight_state_pkg::S_B_ATTACK_PULL;
					default: m_state[idx] = fight_state_pkg::S_IDLE;
				endcase
			end
		end else begin
			m_cnt[idx] = 0;
			if (atk)
				m_state[idx] = fight_state_pkg::S_B_ATTACK_START;
			else if (fwd)
				m_state[idx] = fight_state_pkg::S_MOVEFORWARD;
			else if (bwd)
				m_state[idx] = fight_state_pkg::S_MOVEBACKWARDS;
			else
				m_state[idx] = fight_state_pkg::S_IDLE;
			if (m_state[idx] == fight_state_pkg::S_MOVEFORWARD)
				move = MOVE_STEP;
			else if (m_state[idx] == fight_state_pkg::S_MOVEBACKWARDS)
				move = -MOVE_STEP;
		end
		// p2 faces left, its forward is toward smaller x.
		if (idx == 1)
			move = -move;
		m_x[idx] = m_x[idx] + move;
		if (m_x[idx] > arena_geom_pkg::ARENA_MAX_X)
			m_x[idx] = arena_geom_pkg::ARENA_MAX_X;
		if (m_x[idx] < arena_geom_pkg::ARENA_MIN_X)
			m_x[idx] = arena_geom_pkg::ARENA_MIN_X;
	endtask

	task automatic model_step();
		logic [1:0] hit;
		logic [1:0] rise;
		bit out_of_health;
		if (!rst_n) begin
			model_reset();
		end else if (frame_tick && !m_game_over) begin
			hit = expected_hit();
			rise = hit & ~m_prev_hit;
			m_prev_hit = hit;
			out_of_health = m_health[0] == 0 || m_health[1] == 0;
			if (rise[0])
				m_health[0] = damaged(m_health[0]);
			if (rise[1])
				m_health[1] = damaged(m_health[1]);
			hits_landed += rise[0] + rise[1];
			m_game_over = out_of_health;
			if (out_of_health)
				game_overs++;
			advance_fighter(0, p1_forward, p1_backward, p1_attack);
			advance_fighter(1, p2_forward, p2_backward, p2_attack);
		end
	endtask

	// steer the fighters into arm range and keep them trading blows.
	function automatic logic [2:0] pick_buttons(input int gap);
		logic [31:0] r;
		r = $random(seed);
		if (gap > 90)
			return {r[5:3] == 3'd0, r[1:0] != 2'd0, r[2]};
		if (gap < 30)
			return {r[5:4] == 2'd0, r[1:0] == 2'd0, r[3:2] != 2'd0};
		return {r[3:2] == 2'd0, r[0], r[1]};
	endfunction

	task automatic drive_inputs(input int cycle);
		logic [31:0] r;
		r = $random(seed);
		rst_n <= cycle >= 1 && !(cycle >= RESET_AGAIN_AT && cycle < RESET_AGAIN_AT + 2);
		frame_tick <= r[7:0] < 8'd86;
		{p1_attack, p1_forward, p1_backward} <= pick_buttons(m_x[1] - m_x[0]);
		{p2_attack, p2_forward, p2_backward} <= pick_buttons(m_x[1] - m_x[0]);
	endtask

	task automatic check_field(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		assert (actual === expected) else begin
			$display("mismatch %s: dut 0x%0h, model 0x%0h at %0t", name, actual, expected,
				$time);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic check_outputs();
		check_field("p1_state", 16'(p1_state), 16'(m_state[0]));
		check_field("p2_state", 16'(p2_state), 16'(m_state[1]));
		check_field("p1_x", 16'(p1_x), 16'(m_x[0]));
		check_field("p2_x", 16'(p2_x), 16'(m_x[1]));
		check_field("hit_result", 16'(hit_result), 16'(expected_hit()));
		check_field("p1_health", 16'(p1_health), 16'(m_health[0]));
		check_field("p2_health", 16'(p2_health), 16'(m_health[1]));
		check_field("game_over", 16'(game_over), 16'(m_game_over));
		assert (u_dut.u_asserts.assert_fails == 0) else begin
			$display("CHECKS FAILED");
			$fatal(1, "a concurrent assertion on the DUT outputs failed at %0t", $time);
		end
	endtask

	initial begin
		model_reset();
		for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
			@(posedge clk);
			model_step();
			drive_inputs(cycle);
			@(negedge clk);
			check_outputs();
		end
		if (game_overs > 0) begin
			$display("%0d cycles, %0d hits landed, %0d game overs", NUM_CYCLES, hits_landed,
				game_overs);
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1, "no game over was reached, so the freeze was never exercised");
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("CHECKS FAILED");
		$fatal(1, "timeout, the run did not end within %0d clock periods", WATCHDOG_CYCLES);
	end

endmodule

//--- flist.f
verilog/fight_state_pkg.sv
verilog/arena_geom_pkg.sv
verilog/fighter_fsm.sv
verilog/fighter_boxes.sv
verilog/collision_detect.sv
verilog/hit_detect.sv
verilog/health_tracker.sv
verilog/fight_core.sv
dv/fight_core_asserts.sv
dv/fight_core_tb.sv

//--- Bender.yml
package:
  name: fight_core

sources:
  - verilog/fight_state_pkg.sv
  - verilog/arena_geom_pkg.sv
  - verilog/fighter_fsm.sv
  - verilog/fighter_boxes.sv
  - verilog/collision_detect.sv
  - verilog/hit_detect.sv
  - verilog/health_tracker.sv
  - verilog/fight_core.sv
  - target: test
    files:
      - dv/fight_core_asserts.sv
      - dv/fight_core_tb.sv
